/* hdl/obi_pkg.sv */
// obi request and response structs, test peripheral address map, result codes and timer irq id
package obi_pkg;

  // request from the requester toward memory
  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
  } obi_req_t;

  // response back to the requester
  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic        err;
    logic [31:0] rdata;
  } obi_resp_t;

  // character output, low byte of wdata
  localparam logic [31:0] PRINT_ADDR      = 32'h1000_0000;

  // timer registers
  localparam logic [31:0] TIMER_MASK_ADDR = 32'h1500_0000;
  localparam logic [31:0] TIMER_CNT_ADDR  = 32'h1500_0004;
  localparam logic [31:0] TIMER_RD_ADDR   = 32'h1500_1000;

  // test result and exit
  localparam logic [31:0] RESULT_ADDR     = 32'h2000_0000;
  localparam logic [31:0] EXIT_ADDR       = 32'h2000_0004;

  // values written to RESULT_ADDR
  localparam logic [31:0] PASS_CODE       = 32'd123456789;
  localparam logic [31:0] FAIL_CODE       = 32'd1;

  // interrupt id of the timer, also its enable bit in the mask register
  localparam logic [4:0]  TIMER_IRQ_ID    = 5'd7;

endpackage

/* hdl/sram_bank.sv */
// sram_bank: single-port word memory with byte enables and registered read data
`timescale 1ns/1ps

module sram_bank #(
  parameter int NUM_WORDS = 8192
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         req_i,
  input  logic                         we_i,
  input  logic [$clog2(NUM_WORDS)-1:0] addr_i,
  input  logic [31:0]                  wdata_i,
  input  logic [3:0]                   be_i,
  output logic [31:0]                  rdata_o
);

  // word array, preloadable from a hex image
  logic [31:0] mem [NUM_WORDS];

  // byte-enabled write
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int i = 0; i < 4; i++) begin
        if (be_i[i]) begin
          mem[addr_i][8*i +: 8] <= wdata_i[8*i +: 8];
        end
      end
    end
  end

  // read word is held until the next read
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_o <= '0;
    end else if (req_i && !we_i) begin
      rdata_o <= mem[addr_i];
    end
  end

endmodule

/* hdl/data_decoder.sv */
// data_decoder: data port address decode, ram forwarding, peripheral strobes and response mux
`timescale 1ns/1ps

module data_decoder import obi_pkg::*; #(
  parameter int NUM_BYTES = 65536
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  obi_req_t                       data_req_i,
  input  logic [31:0]                    ram_rdata_i,
  input  logic [31:0]                    timer_cnt_i,
  output obi_resp_t                      data_resp_o,
  output logic                           ram_req_o,
  output logic                           ram_we_o,
  output logic [$clog2(NUM_BYTES/8)-1:0] ram_addr_o,
  output logic [31:0]                    ram_wdata_o,
  output logic [3:0]                     ram_be_o,
  output logic                           timer_mask_wr_o,
  output logic                           timer_cnt_wr_o,
  output logic [31:0]                    timer_wdata_o,
  output logic                           print_valid_o,
  output logic [7:0]                     print_char_o,
  output logic                           tests_passed_o,
  output logic                           tests_failed_o,
  output logic                           exit_valid_o,
  output logic [31:0]                    exit_value_o
);

  localparam int WORD_AW = $clog2(NUM_BYTES/8);

  typedef enum logic [1:0] {
    T_IDLE,
    T_RAM,
    T_PER,
    T_ERR
  } access_t;

  access_t     access_d, access_q;
  logic        is_ram;
  logic        wr;
  logic        rd;
  logic        timer_rd;
  logic        rvalid_q;
  logic [31:0] timer_rdata_q;

  assign is_ram   = data_req_i.addr < 32'(NUM_BYTES);
  assign wr       = data_req_i.req && data_req_i.we;
  assign rd       = data_req_i.req && !data_req_i.we;
  assign timer_rd = rd && !is_ram && (data_req_i.addr == TIMER_RD_ADDR);

  // classify the request
  always_comb begin
    access_d = T_IDLE;
    if (data_req_i.req) begin
      if (is_ram) begin
        access_d = T_RAM;
      end else if (data_req_i.we) begin
        if (data_req_i.addr == PRINT_ADDR      ||
            data_req_i.addr == TIMER_MASK_ADDR ||
            data_req_i.addr == TIMER_CNT_ADDR  ||
            data_req_i.addr == RESULT_ADDR     ||
            data_req_i.addr == EXIT_ADDR) begin
          access_d = T_PER;
        end else begin
          access_d = T_ERR;
        end
      end else if (timer_rd) begin
        access_d = T_PER;
      end else begin
        access_d = T_ERR;
      end
    end
  end

  // ram side, upper half of the range aliases onto the bank
  assign ram_req_o   = data_req_i.req && is_ram;
  assign ram_we_o    = data_req_i.we;
  assign ram_addr_o  = data_req_i.addr[WORD_AW+1:2];
  assign ram_wdata_o = data_req_i.wdata;
  assign ram_be_o    = data_req_i.be;

  // timer strobes, applied at the accepting edge
  assign timer_mask_wr_o = wr && (data_req_i.addr == TIMER_MASK_ADDR);
  assign timer_cnt_wr_o  = wr && (data_req_i.addr == TIMER_CNT_ADDR);
  assign timer_wdata_o   = data_req_i.wdata;

  // pulses in the accepting cycle
  always_comb begin
    print_valid_o  = wr && (data_req_i.addr == PRINT_ADDR);
    print_char_o   = print_valid_o ? data_req_i.wdata[7:0] : '0;
    tests_passed_o = wr && (data_req_i.addr == RESULT_ADDR) && (data_req_i.wdata == PASS_CODE);
    tests_failed_o = wr && (data_req_i.addr == RESULT_ADDR) && (data_req_i.wdata == FAIL_CODE);
    exit_valid_o   = wr && (data_req_i.addr == EXIT_ADDR);
    exit_value_o   = exit_valid_o ? data_req_i.wdata : '0;
  end

  // access class and rvalid for the response cycle
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      access_q <= T_IDLE;
      rvalid_q <= 1'b0;
    end else begin
      access_q <= access_d;
      rvalid_q <= data_resp_o.gnt;
    end
  end

  // count seen at acceptance, zero for peripheral writes
  always_ff @(posedge clk_i) begin
    timer_rdata_q <= timer_rd ? timer_cnt_i : '0;
  end

  // every request is granted right away
  always_comb begin
    data_resp_o.gnt    = data_req_i.req;
    data_resp_o.rvalid = rvalid_q;
    data_resp_o.err    = (access_q == T_ERR);
    case (access_q)
      T_RAM:   data_resp_o.rdata = ram_rdata_i;
      T_PER:   data_resp_o.rdata = timer_rdata_q;
      default: data_resp_o.rdata = '0;
    endcase
  end

endmodule

/* hdl/timer_irq.sv */
// timer_irq: countdown timer with mask register and acknowledge-cleared interrupt
`timescale 1ns/1ps

module timer_irq import obi_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        mask_wr_i,
  input  logic        cnt_wr_i,
  input  logic [31:0] wdata_i,
  input  logic        irq_ack_i,
  input  logic [4:0]  irq_id_i,
  output logic [31:0] cnt_o,
  output logic        irq_timer_o
);

  logic [31:0] mask_q;
  logic [31:0] cnt_q;
  logic        irq_q;
  logic        expire;

  // count passes from 1 to 0 at this edge
  assign expire = !cnt_wr_i && (cnt_q == 32'd1);

  // mask register
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      mask_q <= '0;
    end else if (mask_wr_i) begin
      mask_q <= wdata_i;
    end
  end

  // a load wins over counting
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (cnt_wr_i) begin
      cnt_q <= wdata_i;
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 32'd1;
    end
  end

  // interrupt stays up until acknowledged with the timer id
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      irq_q <= 1'b0;
    end else if (expire && mask_q[TIMER_IRQ_ID]) begin
      irq_q <= 1'b1;
    end else if (irq_ack_i && (irq_id_i == TIMER_IRQ_ID)) begin
      irq_q <= 1'b0;
    end
  end

  assign cnt_o       = cnt_q;
  assign irq_timer_o = irq_q;

endmodule

/* hdl/mm_ram.sv */
// mm_ram: instruction and data sram banks, data port decoder, test timer and instruction response
`timescale 1ns/1ps

module mm_ram import obi_pkg::*; #(
  parameter int NUM_BYTES = 65536
) (
  input  logic        clk_i,
  input  logic        rst_ni,

  input  obi_req_t    instr_req_i,
  output obi_resp_t   instr_resp_o,

  input  obi_req_t    data_req_i,
  output obi_resp_t   data_resp_o,

  input  logic [4:0]  irq_id_i,
  input  logic        irq_ack_i,
  output logic        irq_timer_o,

  output logic        print_valid_o,
  output logic [7:0]  print_char_o,
  output logic        tests_passed_o,
  output logic        tests_failed_o,
  output logic        exit_valid_o,
  output logic [31:0] exit_value_o
);

  // each bank holds half of NUM_BYTES
  localparam int NUM_WORDS = NUM_BYTES/8;
  localparam int WORD_AW   = $clog2(NUM_WORDS);

  logic               instr_rvalid_q;
  logic [31:0]        instr_rdata;

  logic               ram_req;
  logic               ram_we;
  logic [WORD_AW-1:0] ram_addr;
  logic [31:0]        ram_wdata;
  logic [3:0]         ram_be;
  logic [31:0]        ram_rdata;

  logic               timer_mask_wr;
  logic               timer_cnt_wr;
  logic [31:0]        timer_wdata;
  logic [31:0]        timer_cnt;

  // instruction bank is read only from the bus
  sram_bank #(
    .NUM_WORDS (NUM_WORDS)
  ) i_instr_bank (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (instr_req_i.req),
    .we_i    (1'b0),
    .addr_i  (instr_req_i.addr[WORD_AW+1:2]),
    .wdata_i ('0),
    .be_i    (4'b1111),
    .rdata_o (instr_rdata)
  );

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      instr_rvalid_q <= 1'b0;
    end else begin
      instr_rvalid_q <= instr_resp_o.gnt;
    end
  end

  always_comb begin
    instr_resp_o.gnt    = instr_req_i.req;
    instr_resp_o.rvalid = instr_rvalid_q;
    instr_resp_o.err    = 1'b0;
    instr_resp_o.rdata  = instr_rdata;
  end

  sram_bank #(
    .NUM_WORDS (NUM_WORDS)
  ) i_data_bank (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (ram_req),
    .we_i    (ram_we),
    .addr_i  (ram_addr),
    .wdata_i (ram_wdata),
    .be_i    (ram_be),
    .rdata_o (ram_rdata)
  );

  data_decoder #(
    .NUM_BYTES (NUM_BYTES)
  ) i_data_decoder (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .data_req_i      (data_req_i),
    .ram_rdata_i     (ram_rdata),
    .timer_cnt_i     (timer_cnt),
    .data_resp_o     (data_resp_o),
    .ram_req_o       (ram_req),
    .ram_we_o        (ram_we),
    .ram_addr_o      (ram_addr),
    .ram_wdata_o     (ram_wdata),
    .ram_be_o        (ram_be),
    .timer_mask_wr_o (timer_mask_wr),
    .timer_cnt_wr_o  (timer_cnt_wr),
    .timer_wdata_o   (timer_wdata),
    .print_valid_o   (print_valid_o),
    .print_char_o    (print_char_o),
    .tests_passed_o  (tests_passed_o),
    .tests_failed_o  (tests_failed_o),
    .exit_valid_o    (exit_valid_o),
    .exit_value_o    (exit_value_o)
  );

  timer_irq i_timer_irq (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .mask_wr_i   (timer_mask_wr),
    .cnt_wr_i    (timer_cnt_wr),
    .wdata_i     (timer_wdata),
    .irq_ack_i   (irq_ack_i),
    .irq_id_i    (irq_id_i),
    .cnt_o       (timer_cnt),
    .irq_timer_o (irq_timer_o)
  );

endmodule

/* tb/clk_rst_gen.sv */
// clk_rst_gen: free-running testbench clock and active-low reset held for a number of cycles
`timescale 1ns/1ps

module clk_rst_gen #(
  parameter int CLK_PERIOD_NS = 100,
  parameter int RST_CYCLES    = 8
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(CLK_PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // release away from the rising edge
  initial begin
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

/* tb/mm_ram_checker.sv */
// mm_ram_checker: concurrent assertions on obi handshakes, result pulses and timer irq clearing
`timescale 1ns/1ps

module mm_ram_checker import obi_pkg::*; (
  input logic       clk_i,
  input logic       rst_ni,
  input obi_req_t   instr_req_i,
  input obi_resp_t  instr_resp_o,
  input obi_req_t   data_req_i,
  input obi_resp_t  data_resp_o,
  input logic [4:0] irq_id_i,
  input logic       irq_ack_i,
  input logic       irq_timer_o,
  input logic       tests_passed_o,
  input logic       tests_failed_o
);

  // read back by the testbench top at the end of the run
  int unsigned assert_fails = 0;

  // one rvalid exactly one cycle after each accepted request
  instr_rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (instr_req_i.req && instr_resp_o.gnt) |=> instr_resp_o.rvalid)
    else begin $error("instruction rvalid missing after grant"); assert_fails++; end
  data_rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (data_req_i.req && data_resp_o.gnt) |=> data_resp_o.rvalid)
    else begin $error("data rvalid missing after grant"); assert_fails++; end

  // no response without an accepted request
  instr_rvalid_has_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_resp_o.rvalid |-> $past(instr_req_i.req && instr_resp_o.gnt))
    else begin $error("instruction rvalid without a request"); assert_fails++; end
  data_rvalid_has_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_resp_o.rvalid |-> $past(data_req_i.req && data_resp_o.gnt))
    else begin $error("data rvalid without a request"); assert_fails++; end

  passed_failed_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(tests_passed_o && tests_failed_o))
    else begin $error("passed and failed pulses at once"); assert_fails++; end

  // irq only drops on an acknowledge with the timer id
  irq_falls_on_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $fell(irq_timer_o) |-> $past(irq_ack_i && (irq_id_i == TIMER_IRQ_ID)))
    else begin $error("timer irq cleared without acknowledge"); assert_fails++; end

endmodule

bind mm_ram mm_ram_checker i_mm_ram_checker (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .instr_req_i    (instr_req_i),
  .instr_resp_o   (instr_resp_o),
  .data_req_i     (data_req_i),
  .data_resp_o    (data_resp_o),
  .irq_id_i       (irq_id_i),
  .irq_ack_i      (irq_ack_i),
  .irq_timer_o    (irq_timer_o),
  .tests_passed_o (tests_passed_o),
  .tests_failed_o (tests_failed_o)
);

/* tb/mm_ram_tb.sv */
// mm_ram_tb: stimulus file driven checks of both obi ports, test peripherals and timer irq
`timescale 1ns/1ps

module mm_ram_tb import obi_pkg::*; ();

  localparam int    NUM_BYTES = 65536;
  localparam string STIM_FILE = "tb/mm_ram_stim.txt";

  logic        clk_i;
  logic        rst_ni;
  obi_req_t    instr_req;
  obi_resp_t   instr_resp;
  obi_req_t    data_req;
  obi_resp_t   data_resp;
  logic [4:0]  irq_id;
  logic        irq_ack;
  logic        irq_timer;
  logic        print_valid;
  logic [7:0]  print_char;
  logic        tests_passed;
  logic        tests_failed;
  logic        exit_valid;
  logic [31:0] exit_value;
  int          num_ops;
  bit          ops_counted;

  clk_rst_gen i_clk_rst_gen (
    .clk_o  (clk_i),
    .rst_no (rst_ni)
  );

  mm_ram #(
    .NUM_BYTES (NUM_BYTES)
  ) i_mm_ram (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .instr_req_i    (instr_req),
    .instr_resp_o   (instr_resp),
    .data_req_i     (data_req),
    .data_resp_o    (data_resp),
    .irq_id_i       (irq_id),
    .irq_ack_i      (irq_ack),
    .irq_timer_o    (irq_timer),
    .print_valid_o  (print_valid),
    .print_char_o   (print_char),
    .tests_passed_o (tests_passed),
    .tests_failed_o (tests_failed),
    .exit_valid_o   (exit_valid),
    .exit_value_o   (exit_value)
  );

  task automatic check_eq(input logic [31:0] observed, input logic [31:0] expected,
                          input string what);
    if (observed !== expected) begin
      $display("Error at time %0t: %s is %h, expected %h", $time, what, observed, expected);
      $display("TEST FAILED");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  // next operation line, comment lines start with #
  task automatic read_op(input int fd, output byte op, output logic [31:0] a,
                         output logic [31:0] b, output logic [31:0] c,
                         output logic [31:0] d, output bit got);
    int n;
    int ch;
    got = 1'b0;
    n = $fscanf(fd, " %c", op);
    while (n == 1 && op == "#") begin
      ch = $fgetc(fd);
      // 10 is newline
      while (ch != 10 && ch != -1) begin
        ch = $fgetc(fd);
      end
      n = $fscanf(fd, " %c", op);
    end
    if (n == 1) begin
      n = $fscanf(fd, " %h %h %h %h", a, b, c, d);
      if (n != 4) begin
        $display("malformed stimulus line for operation %c", op);
        $display("TEST FAILED");
        $fatal(1, "bad stimulus file");
      end
      got = 1'b1;
    end
  endtask

  // one data port transfer, pulses checked in the accepting cycle
  task automatic data_access(input logic we, input logic [31:0] addr, input logic [3:0] be,
                             input logic [31:0] wdata, input logic [31:0] rdata,
                             input logic err);
    logic result_wr;
    logic print_wr;
    logic exit_wr;
    result_wr = we && (addr == RESULT_ADDR);
    print_wr  = we && (addr == PRINT_ADDR);
    exit_wr   = we && (addr == EXIT_ADDR);
    data_req  = '{req: 1'b1, we: we, be: be, addr: addr, wdata: wdata};
    #10;
    check_eq(32'(data_resp.gnt), 32'd1, "data gnt");
    check_eq(32'(print_valid), 32'(print_wr), "print_valid_o");
    check_eq(32'(tests_passed), 32'(result_wr && wdata == PASS_CODE), "tests_passed_o");
    check_eq(32'(tests_failed), 32'(result_wr && wdata == FAIL_CODE), "tests_failed_o");
    check_eq(32'(exit_valid), 32'(exit_wr), "exit_valid_o");
    if (print_wr) begin
      check_eq(32'(print_char), 32'(wdata[7:0]), "print_char_o");
    end
    if (exit_wr) begin
      check_eq(exit_value, wdata, "exit_value_o");
    end
    @(posedge clk_i);
    @(negedge clk_i);
    data_req.req = 1'b0;
    check_eq(32'(data_resp.rvalid), 32'd1, "data rvalid");
    check_eq(32'(data_resp.err), 32'(err), "data err");
    // a ram write answers with stale read data
    if (!we || addr >= 32'(NUM_BYTES)) begin
      check_eq(data_resp.rdata, rdata, "data rdata");
    end
  endtask

  task automatic instr_read(input logic [31:0] addr, input logic [31:0] rdata);
    instr_req = '{req: 1'b1, we: 1'b0, be: 4'hf, addr: addr, wdata: 32'd0};
    #10;
    check_eq(32'(instr_resp.gnt), 32'd1, "instruction gnt");
    @(posedge clk_i);
    @(negedge clk_i);
    instr_req.req = 1'b0;
    check_eq(32'(instr_resp.rvalid), 32'd1, "instruction rvalid");
    check_eq(32'(instr_resp.err), 32'd0, "instruction err");
    check_eq(instr_resp.rdata, rdata, "instruction rdata");
  endtask

  // delay 0 means the irq must stay low
  task automatic timer_load(input logic [31:0] count, input logic [31:0] delay);
    int unsigned edges;
    data_access(1'b1, TIMER_CNT_ADDR, 4'hf, count, 32'd0, 1'b0);
    edges = 0;
    while (irq_timer !== 1'b1 && edges < count + 4) begin
      @(posedge clk_i);
      edges++;
      @(negedge clk_i);
    end
    if (delay != 0) begin
      check_eq(edges, delay, "edges from count load to irq_timer_o");
    end else begin
      check_eq(32'(irq_timer), 32'd0, "irq_timer_o with the timer masked");
    end
  endtask

  task automatic irq_acknowledge(input logic [4:0] id, input logic irq_after);
    irq_ack = 1'b1;
    irq_id  = id;
    @(posedge clk_i);
    @(negedge clk_i);
    irq_ack = 1'b0;
    check_eq(32'(irq_timer), 32'(irq_after), "irq_timer_o after acknowledge");
  endtask

  initial begin
    int          fd;
    byte         op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] d;
    bit          got;
    instr_req = '0;
    data_req  = '0;
    irq_id    = '0;
    irq_ack   = 1'b0;
    num_ops   = 0;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("cannot open the stimulus file %s", STIM_FILE);
      $display("TEST FAILED");
      $fatal(1, "no stimulus");
    end
    // first pass counts operations and builds the instruction image
    got = 1'b1;
    while (got) begin
      read_op(fd, op, a, b, c, d, got);
      if (got) begin
        num_ops++;
        if (op == "I") begin
          i_mm_ram.i_instr_bank.mem[a[14:2]] <= b;
        end
      end
    end
    $fclose(fd);
    ops_counted = 1'b1;
    wait (rst_ni === 1'b1);
    @(negedge clk_i);
    fd  = $fopen(STIM_FILE, "r");
    got = 1'b1;
    while (got) begin
      read_op(fd, op, a, b, c, d, got);
      if (got) begin
        case (op)
          "W": data_access(1'b1, a, b[3:0], c, 32'd0, d[0]);
          "R": data_access(1'b0, a, 4'hf, 32'd0, b, c[0]);
          "I": instr_read(a, b);
          "T": timer_load(a, b);
          "A": irq_acknowledge(a[4:0], b[0]);
          "N": repeat (a) @(negedge clk_i);
          default: begin
            $display("unknown stimulus operation %c", op);
            $display("TEST FAILED");
            $fatal(1, "bad stimulus file");
          end
        endcase
      end
    end
    $fclose(fd);
    repeat (2) @(negedge clk_i);
    if (i_mm_ram.i_mm_ram_checker.assert_fails != 0) begin
      $display("TEST FAILED");
      $fatal(1, "assertion failure in the bound checker");
    end else begin
      $display("TEST PASSED");
      $finish;
    end
  end

  // first assertion failure of the checker ends the run
  initial begin
    wait (i_mm_ram.i_mm_ram_checker.assert_fails != 0);
    $display("TEST FAILED");
    $fatal(1, "assertion failure in the bound checker");
  end

  // watchdog, 20 cycles per operation plus one slot for reset
  initial begin
    wait (ops_counted);
    repeat (20 * (num_ops + 1)) @(posedge clk_i);
    $display("watchdog expired, the stimulus did not finish in time");
    $display("TEST FAILED");
    $fatal(1, "timeout");
  end

endmodule

/* tb/mm_ram_stim.txt */
# columns: op a b c d, all hex, every line carries four fields
# W addr be wdata err | R addr rdata err 0 | I addr rdata 0 0 | T count delay 0 0 | A id irq 0 0 | N cycles 0 0 0
W 00000100 f 11223344 0
W 00000104 f aabbccdd 0
W 00000100 3 0000eeff 0
W 00000104 c 55660000 0
R 00000100 1122eeff 0 0
R 00000104 5566ccdd 0 0
W 00000108 f 00000000 0
W 00000108 5 a1b2c3d4 0
R 00000108 00b200d4 0 0
I 00000000 00000013 0 0
I 00000004 deadbeef 0 0
I 00000008 12345678 0 0
I 00007ffc cafef00d 0 0
W 10000000 f 00000041 0
W 20000000 f 075bcd15 0
W 20000000 f 00000001 0
W 20000000 f 00000002 0
W 20000004 f 0000002a 0
W 15000004 f 00000010 0
R 15001000 00000010 0 0
R 15001000 0000000f 0 0
T 00000003 00000000 0 0
W 15000000 f 00000080 0
T 00000005 00000005 0 0
N 00000003 0 0 0
A 00000003 00000001 0 0
A 00000007 00000000 0 0
T 00000001 00000001 0 0
A 00000007 00000000 0 0
R 30000000 00000000 1 0
W 30000000 f 12345678 1
R 00010000 00000000 1 0
R 10000000 00000000 1 0
N 00000002 0 0 0

/* all.f */
hdl/obi_pkg.sv
hdl/sram_bank.sv
hdl/data_decoder.sv
hdl/timer_irq.sv
hdl/mm_ram.sv
tb/clk_rst_gen.sv
tb/mm_ram_checker.sv
tb/mm_ram_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := mm_ram_tb
FILELIST   := all.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
RUN_ARGS   := +verilator+error+limit+100
LOG        := sim.log
PASS_MSG   := TEST PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
